// File: hdl/butterfly_unit.sv
`default_nettype none

module butterfly_unit (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       issue,
    input  ntt_params_pkg::tw_addr_t   tw_addr,
    input  logic                       tw_we,
    input  ntt_params_pkg::coef_t      tw_wdata,
    output logic                       idle,
    coef_mem_if.bfly                   mem
);
    import ntt_params_pkg::*;

    localparam int EST_W = PROD_W + BARRETT_W;
    localparam int REM_W = COEF_W + 2;  // holds anything below 3q
    localparam int SUM_W = COEF_W + 1;

    function automatic coef_t mod_add(coef_t x, coef_t y);
        logic [SUM_W-1:0] s;
        s = {1'b0, x} + {1'b0, y};
        if (s >= SUM_W'(MODULUS)) begin
            s = s - SUM_W'(MODULUS);
        end
        return coef_t'(s);
    endfunction

    function automatic coef_t mod_sub(coef_t x, coef_t y);
        logic [SUM_W-1:0] d;
        d = {1'b0, x} - {1'b0, y};
        if (x < y) begin
            d = d + SUM_W'(MODULUS);  // wraps back into [0, q)
        end
        return coef_t'(d);
    endfunction

    coef_t tw_mem [RING_SIZE/2];

    logic  v1, v2, v3;  // one valid bit per stage
    coef_t s1_a, s1_b, s1_tw;
    addr_t s1_addr_a, s1_addr_b;
    coef_t s2_a;
    prod_t s2_prod;
    addr_t s2_addr_a, s2_addr_b;
    coef_t s3_sum, s3_diff;
    addr_t s3_addr_a, s3_addr_b;

    logic [EST_W-1:0]     est;
    logic [BARRETT_W-1:0] quot;
    logic [REM_W-1:0]     rem;
    coef_t                t_red;

    always_ff @(posedge clk) begin
        if (tw_we) begin
            tw_mem[tw_addr] <= tw_wdata;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            v1 <= 1'b0;
            v2 <= 1'b0;
            v3 <= 1'b0;
        end else begin
            v1 <= issue;
            v2 <= v1;
            v3 <= v2;
        end
    end

    // Barrett estimate, then at most two corrections
    always_comb begin
        est   = EST_W'(s2_prod) * EST_W'(BARRETT_M);
        quot  = est[EST_W-1:BARRETT_K];
        rem   = REM_W'(s2_prod) - REM_W'(quot * MODULUS);  // exact, true value < 2^REM_W
        if (rem >= REM_W'(MODULUS)) begin
            rem = rem - REM_W'(MODULUS);
        end
        if (rem >= REM_W'(MODULUS)) begin
            rem = rem - REM_W'(MODULUS);
        end
        t_red = coef_t'(rem);
    end

    always_ff @(posedge clk) begin
        // stage 1: operands, addresses and twiddle
        s1_a      <= mem.rd_data_a;
        s1_b      <= mem.rd_data_b;
        s1_addr_a <= mem.rd_addr_a;
        s1_addr_b <= mem.rd_addr_b;
        s1_tw     <= tw_mem[tw_addr];
        // stage 2: b * w
        s2_prod   <= s1_b * s1_tw;
        s2_a      <= s1_a;
        s2_addr_a <= s1_addr_a;
        s2_addr_b <= s1_addr_b;
        // stage 3: reduce and add/sub
        s3_sum    <= mod_add(s2_a, t_red);
        s3_diff   <= mod_sub(s2_a, t_red);
        s3_addr_a <= s2_addr_a;
        s3_addr_b <= s2_addr_b;
    end

    assign mem.wr_en     = v3;
    assign mem.wr_addr_a = s3_addr_a;
    assign mem.wr_addr_b = s3_addr_b;
    assign mem.wr_data_a = s3_sum;
    assign mem.wr_data_b = s3_diff;

    // a butterfly in stage 3 commits at this edge, so next cycle's reads see it
    assign idle = !(v1 || v2);

    wb_follows_issue: assert property (
        @(posedge clk) disable iff (reset)
        mem.wr_en |-> $past(issue, BFLY_LATENCY)
    ) else $error("butterfly_unit: write-back without matching issue");

endmodule

`default_nettype wire

// File: hdl/coef_mem_if.sv
`default_nettype none

// two combinational read ports, the paired butterfly write and the load write
interface coef_mem_if;
    import ntt_params_pkg::*;

    addr_t rd_addr_a;
    addr_t rd_addr_b;
    coef_t rd_data_a;
    coef_t rd_data_b;

    logic  wr_en;      // butterfly write-back
    addr_t wr_addr_a;
    addr_t wr_addr_b;
    coef_t wr_data_a;
    coef_t wr_data_b;

    logic  ld_en;      // one coefficient per cycle while loading
    addr_t ld_addr;
    coef_t ld_data;

    modport mem (
        input  rd_addr_a, rd_addr_b,
        output rd_data_a, rd_data_b,
        input  wr_en, wr_addr_a, wr_addr_b, wr_data_a, wr_data_b,
        input  ld_en, ld_addr, ld_data
    );

    modport seq (
        output rd_addr_a, rd_addr_b,
        input  rd_data_a,
        output ld_en, ld_addr, ld_data
    );

    modport bfly (
        input  rd_addr_a, rd_addr_b, rd_data_a, rd_data_b,
        output wr_en, wr_addr_a, wr_addr_b, wr_data_a, wr_data_b
    );

endinterface

`default_nettype wire

// File: hdl/coef_ram.sv
`default_nettype none

module coef_ram (
    input  logic     clk,
    input  logic     reset,
    coef_mem_if.mem  mem
);
    import ntt_params_pkg::*;

    coef_t regs [RING_SIZE];

    // the load phase and the run never overlap, so one write source per edge
    always_ff @(posedge clk) begin
        if (mem.ld_en) begin
            regs[mem.ld_addr] <= mem.ld_data;
        end else if (mem.wr_en) begin
            regs[mem.wr_addr_a] <= mem.wr_data_a;  // a + t
            regs[mem.wr_addr_b] <= mem.wr_data_b;  // a - t
        end
    end

    assign mem.rd_data_a = regs[mem.rd_addr_a];
    assign mem.rd_data_b = regs[mem.rd_addr_b];

    // sequencer loads and butterfly write-back must not collide
    load_vs_writeback: assert property (
        @(posedge clk) disable iff (reset)
        !(mem.ld_en && mem.wr_en)
    ) else $error("coef_ram: load and butterfly write in the same cycle");

    // a butterfly always pairs two distinct words
    paired_addr_distinct: assert property (
        @(posedge clk) disable iff (reset)
        mem.wr_en |-> (mem.wr_addr_a != mem.wr_addr_b)
    ) else $error("coef_ram: paired write to one address");

endmodule

`default_nettype wire

// File: hdl/ntt_core.sv
`default_nettype none

module ntt_core (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     cmd_valid,
    output logic                     cmd_ready,
    input  ntt_ctrl_pkg::ntt_cmd_e   cmd,
    input  logic                     in_valid,
    output logic                     in_ready,
    input  ntt_params_pkg::coef_t    in_data,
    output logic                     out_valid,
    input  logic                     out_ready,
    output ntt_params_pkg::coef_t    out_data,
    output logic                     busy
);
    import ntt_params_pkg::*;

    // sequencer to butterfly
    logic     issue;
    tw_addr_t tw_addr;
    logic     tw_we;
    coef_t    tw_wdata;
    logic     idle;

    coef_mem_if mem_if ();

    ntt_sequencer seq_i (
        .clk       (clk),
        .reset     (reset),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd       (cmd),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data),
        .busy      (busy),
        .issue     (issue),
        .tw_addr   (tw_addr),
        .tw_we     (tw_we),
        .tw_wdata  (tw_wdata),
        .idle      (idle),
        .mem       (mem_if.seq)
    );

    coef_ram ram_i (
        .clk   (clk),
        .reset (reset),
        .mem   (mem_if.mem)
    );

    butterfly_unit bfly_i (
        .clk      (clk),
        .reset    (reset),
        .issue    (issue),
        .tw_addr  (tw_addr),
        .tw_we    (tw_we),
        .tw_wdata (tw_wdata),
        .idle     (idle),
        .mem      (mem_if.bfly)
    );

endmodule

`default_nettype wire

// File: hdl/ntt_ctrl_pkg.sv
`default_nettype none

// command and sequencer encodings
package ntt_ctrl_pkg;

    typedef enum logic [1:0] {
        CMD_LOAD_TW   = 2'd0,
        CMD_LOAD_DATA = 2'd1,
        CMD_RUN       = 2'd2
    } ntt_cmd_e;

    typedef enum logic [2:0] {
        IDLE      = 3'd0,
        LOAD_TW   = 3'd1,
        LOAD_DATA = 3'd2,
        RUN       = 3'd3,
        DRAIN     = 3'd4,  // wait for the butterfly pipeline to empty
        UNLOAD    = 3'd5
    } seq_state_e;

    localparam int BFLY_PER_STAGE = ntt_params_pkg::RING_SIZE / 2;
    localparam int TW_BEATS       = BFLY_PER_STAGE;  // one twiddle per butterfly slot
    localparam int DATA_BEATS     = ntt_params_pkg::RING_SIZE;
    localparam int LAST_STAGE     = ntt_params_pkg::RING_DEPTH - 1;

endpackage

`default_nettype wire

// File: hdl/ntt_params_pkg.sv
`default_nettype none

// sizes, modulus and data types of the 16-point transform
package ntt_params_pkg;

    localparam int RING_SIZE  = 16;
    localparam int RING_DEPTH = $clog2(RING_SIZE);  // also the number of stages

    localparam int MODULUS = 7681;
    localparam int COEF_W  = 13;
    localparam int PROD_W  = 2 * COEF_W;

    // twiddle memory holds w^0 .. w^(N/2-1)
    localparam int TW_DEPTH = RING_DEPTH - 1;

    // butterfly issue to write-back
    localparam int BFLY_LATENCY = 3;

    // Barrett reduction of a PROD_W-bit product
    // quotient estimate is (p * BARRETT_M) >> BARRETT_K
    // and it is short of the true quotient by at most two
    localparam int BARRETT_K = PROD_W;
    localparam int BARRETT_M = (1 << BARRETT_K) / MODULUS;  // 8736
    localparam int BARRETT_W = $clog2(BARRETT_M + 1);

    typedef logic [COEF_W-1:0]     coef_t;     // residue mod q
    typedef logic [RING_DEPTH-1:0] addr_t;     // coefficient address
    typedef logic [TW_DEPTH-1:0]   tw_addr_t;  // twiddle index
    typedef logic [PROD_W-1:0]     prod_t;     // unreduced product

endpackage

`default_nettype wire

// File: hdl/ntt_sequencer.sv
`default_nettype none

module ntt_sequencer (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       cmd_valid,
    output logic                       cmd_ready,
    input  ntt_ctrl_pkg::ntt_cmd_e     cmd,
    input  logic                       in_valid,
    output logic                       in_ready,
    input  ntt_params_pkg::coef_t      in_data,
    output logic                       out_valid,
    input  logic                       out_ready,
    output ntt_params_pkg::coef_t      out_data,
    output logic                       busy,
    output logic                       issue,
    output ntt_params_pkg::tw_addr_t   tw_addr,
    output logic                       tw_we,
    output ntt_params_pkg::coef_t      tw_wdata,
    input  logic                       idle,
    coef_mem_if.seq                    mem
);
    import ntt_params_pkg::*;
    import ntt_ctrl_pkg::*;

    seq_state_e state;

    addr_t                         beat_cnt;  // load and unload beats
    logic [$clog2(RING_DEPTH)-1:0] stage;
    tw_addr_t                      bfly_cnt;

    logic     cmd_fire, in_fire, out_fire;
    addr_t    beat_rev;
    addr_t    half_span;
    addr_t    low_mask;
    addr_t    bfly_ext;
    addr_t    bfly_addr;
    tw_addr_t bfly_tw;

    assign cmd_ready = (state == IDLE);
    assign in_ready  = (state == LOAD_TW) || (state == LOAD_DATA);
    assign out_valid = (state == UNLOAD);
    assign busy      = (state != IDLE);

    assign cmd_fire = cmd_valid && cmd_ready;
    assign in_fire  = in_valid && in_ready;
    assign out_fire = out_valid && out_ready;

    // data goes in bit-reversed so the run leaves results in natural order
    always_comb begin
        for (int i = 0; i < RING_DEPTH; i++) begin
            beat_rev[i] = beat_cnt[RING_DEPTH-1-i];
        end
    end

    // pair (a, a+h): a is bfly_cnt with a zero slipped in at bit 'stage'
    assign half_span = addr_t'(1) << stage;
    assign low_mask  = half_span - addr_t'(1);
    assign bfly_ext  = addr_t'(bfly_cnt);
    assign bfly_addr = ((bfly_ext & ~low_mask) << 1) | (bfly_ext & low_mask);
    assign bfly_tw   = tw_addr_t'((bfly_ext & low_mask) << (LAST_STAGE - int'(stage)));

    assign issue    = (state == RUN);
    assign tw_addr  = (state == LOAD_TW) ? tw_addr_t'(beat_cnt) : bfly_tw;
    assign tw_we    = (state == LOAD_TW) && in_fire;
    assign tw_wdata = in_data;

    assign mem.ld_en     = (state == LOAD_DATA) && in_fire;
    assign mem.ld_addr   = beat_rev;
    assign mem.ld_data   = in_data;
    assign mem.rd_addr_a = (state == UNLOAD) ? beat_cnt : bfly_addr;
    assign mem.rd_addr_b = bfly_addr | half_span;

    assign out_data = mem.rd_data_a;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= IDLE;
            beat_cnt <= '0;
            stage    <= '0;
            bfly_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    beat_cnt <= '0;
                    stage    <= '0;
                    bfly_cnt <= '0;
                    if (cmd_fire) begin
                        case (cmd)
                            CMD_LOAD_TW:   state <= LOAD_TW;
                            CMD_LOAD_DATA: state <= LOAD_DATA;
                            CMD_RUN:       state <= RUN;
                            default:       state <= IDLE;  // unknown opcode dropped
                        endcase
                    end
                end
                LOAD_TW: begin
                    if (in_fire) begin
                        beat_cnt <= beat_cnt + addr_t'(1);
                        if (beat_cnt == addr_t'(TW_BEATS - 1)) begin
                            state <= IDLE;
                        end
                    end
                end
                LOAD_DATA: begin
                    if (in_fire) begin
                        beat_cnt <= beat_cnt + addr_t'(1);
                        if (beat_cnt == addr_t'(DATA_BEATS - 1)) begin
                            state <= IDLE;
                        end
                    end
                end
                RUN: begin
                    bfly_cnt <= bfly_cnt + tw_addr_t'(1);  // wraps to 0 for the next stage
                    if (bfly_cnt == tw_addr_t'(BFLY_PER_STAGE - 1)) begin
                        state <= DRAIN;
                    end
                end
                DRAIN: begin
                    // stages never overlap
                    if (idle) begin
                        if (int'(stage) == LAST_STAGE) begin
                            state <= UNLOAD;
                        end else begin
                            stage <= stage + 1'b1;
                            state <= RUN;
                        end
                    end
                end
                UNLOAD: begin
                    if (out_fire) begin
                        beat_cnt <= beat_cnt + addr_t'(1);
                        if (beat_cnt == addr_t'(DATA_BEATS - 1)) begin
                            state <= IDLE;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    in_out_exclusive: assert property (
        @(posedge clk) disable iff (reset)
        !(in_ready && out_valid)
    ) else $error("ntt_sequencer: input and output stream active together");

endmodule

`default_nettype wire

// File: ntt_core.f
hdl/ntt_params_pkg.sv
hdl/ntt_ctrl_pkg.sv
hdl/coef_mem_if.sv
hdl/coef_ram.sv
hdl/butterfly_unit.sv
hdl/ntt_sequencer.sv
hdl/ntt_core.sv
tests/tb_clock.sv
tests/ntt_core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the NTT core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module ntt_core_tb -f ntt_core.f -o ntt_core_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/ntt_core_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "Test completed successfully"; then
    exit 0
fi
exit 1

// File: tests/ntt_core_tb.sv
`default_nettype none

module ntt_core_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import ntt_params_pkg::*;
    import ntt_ctrl_pkg::*;

    localparam int WAIT_LIMIT  = 100;     // cycles allowed per handshake wait
    localparam int RUN_LATENCY = 1 + 44;  // handshake cycle plus four stages of 8 + 3
    localparam int NUM_RANDOM  = 5;
    localparam int NUM_STALLED = 2;       // vectors unloaded under back-pressure

    logic     clk;
    logic     reset;
    logic     cmd_valid;
    logic     cmd_ready;
    ntt_cmd_e cmd;
    logic     in_valid;
    logic     in_ready;
    coef_t    in_data;
    logic     out_valid;
    logic     out_ready;
    coef_t    out_data;
    logic     busy;

    integer seed;
    int     value_errors;
    int     timeout_errors;
    coef_t  pw [RING_SIZE];    // w^0 .. w^15
    coef_t  vec [RING_SIZE];   // current input vector
    coef_t  expv [RING_SIZE];  // expected transform

    tb_clock clock_i (.clk(clk), .reset(reset));

    ntt_core dut_i (
        .clk       (clk),
        .reset     (reset),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd       (cmd),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data),
        .busy      (busy)
    );

    function automatic int rand_below(int n);
        int r;
        r = $random(seed);
        return (r & 32'h7fff_ffff) % n;
    endfunction

    function automatic longint mul_mod(longint a, longint b);
        return (a * b) % MODULUS;
    endfunction

    function automatic longint pow_mod(longint b, int e);
        longint r;
        r = 1;
        for (int i = 0; i < e; i++) begin
            r = mul_mod(r, b);
        end
        return r;
    endfunction

    // order divides 16 but not 8, so it is exactly 16
    function automatic longint find_root();
        for (longint c = 2; c < MODULUS; c++) begin
            if (pow_mod(c, RING_SIZE) == 1 && pow_mod(c, RING_SIZE / 2) != 1) begin
                return c;
            end
        end
        return 0;
    endfunction

    // direct sum X[k] = sum x[j] w^(jk)
    task automatic compute_expected();
        longint acc;
        for (int k = 0; k < RING_SIZE; k++) begin
            acc = 0;
            for (int j = 0; j < RING_SIZE; j++) begin
                acc = (acc + mul_mod(vec[j], pw[(j * k) % RING_SIZE])) % MODULUS;
            end
            expv[k] = coef_t'(acc);
        end
    endtask

    task automatic report_mismatch(string name, int expected, int actual);
        value_errors++;
        $display("Fail at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
    endtask

    task automatic report_timeout(string what);
        timeout_errors++;
        $display("Timeout at %0t: %s", $time, what);
    endtask

    task automatic send_command(input ntt_cmd_e op);
        int n;
        cmd_valid <= 1'b1;
        cmd       <= op;
        n = 0;
        @(posedge clk);
        while (!cmd_ready && n < WAIT_LIMIT) begin
            n++;
            @(posedge clk);
        end
        cmd_valid <= 1'b0;
        if (!cmd_ready) begin
            report_timeout("command was never accepted");
        end
    endtask

    // one beat per value, random idle gaps in between
    task automatic send_stream(input int count, input coef_t vals [RING_SIZE]);
        int n;
        int gap;
        for (int i = 0; i < count; i++) begin
            gap = rand_below(3);
            if (gap > 0) begin
                in_valid <= 1'b0;
                repeat (gap) @(posedge clk);
            end
            in_valid <= 1'b1;
            in_data  <= vals[i];
            n = 0;
            @(posedge clk);
            while (!in_ready && n < WAIT_LIMIT) begin
                n++;
                @(posedge clk);
            end
            if (!in_ready) begin
                report_timeout("input beat was never accepted");
            end
        end
        in_valid <= 1'b0;
        @(posedge clk);
        // load must end exactly after the last beat
        if (in_ready !== 1'b0) report_mismatch("in_ready", 0, int'(in_ready));
        if (cmd_ready !== 1'b1) report_mismatch("cmd_ready", 1, int'(cmd_ready));
    endtask

    task automatic run_and_check(input bit stall);
        int    n;
        int    k;
        bit    held_valid;
        coef_t held;
        send_command(CMD_RUN);
        n = 1;
        @(posedge clk);
        while (!out_valid && n < RUN_LATENCY + WAIT_LIMIT) begin
            n++;
            @(posedge clk);
        end
        if (!out_valid) begin
            report_timeout("no output after run command");
        end else if (n != RUN_LATENCY) begin
            report_mismatch("out_valid latency", RUN_LATENCY, n);
        end
        held_valid = out_valid;  // out_ready was low on this edge
        held       = out_data;
        k = 0;
        n = 0;
        out_ready <= stall ? (rand_below(2) == 1) : 1'b1;
        while (k < RING_SIZE && n < 4 * WAIT_LIMIT) begin
            @(posedge clk);
            n++;
            if (out_valid) begin
                if (held_valid && out_data !== held) begin
                    report_mismatch("out_data while stalled", int'(held), int'(out_data));
                end
                if (out_ready) begin
                    if (out_data !== expv[k]) begin
                        report_mismatch($sformatf("out_data[%0d]", k), int'(expv[k]),
                                        int'(out_data));
                    end
                    k++;
                    held_valid = 1'b0;
                end else begin
                    held_valid = 1'b1;
                    held       = out_data;
                end
            end
            out_ready <= stall ? (rand_below(2) == 1) : 1'b1;
        end
        out_ready <= 1'b0;
        if (k < RING_SIZE) begin
            report_timeout("output stream stopped before all results arrived");
        end
        @(posedge clk);
        if (out_valid !== 1'b0) report_mismatch("out_valid", 0, int'(out_valid));
        if (busy !== 1'b0) report_mismatch("busy", 0, int'(busy));
    endtask

    task automatic load_and_run(input bit stall);
        send_command(CMD_LOAD_DATA);
        send_stream(RING_SIZE, vec);
        run_and_check(stall);
    endtask

    initial begin
        int     n;
        longint w;
        $timeformat(-9, 0, " ns", 0);
        seed           = 85;
        value_errors   = 0;
        timeout_errors = 0;
        cmd_valid      = 1'b0;
        cmd            = CMD_LOAD_TW;
        in_valid       = 1'b0;
        in_data        = '0;
        out_ready      = 1'b0;

        w = find_root();
        for (int i = 0; i < RING_SIZE; i++) begin
            pw[i] = coef_t'(pow_mod(w, i));
        end

        n = 0;
        @(posedge clk);
        while (reset && n < WAIT_LIMIT) begin
            n++;
            @(posedge clk);
        end
        if (reset) report_timeout("reset was never released");
        @(posedge clk);
        if (cmd_ready !== 1'b1) report_mismatch("cmd_ready", 1, int'(cmd_ready));
        if (in_ready !== 1'b0) report_mismatch("in_ready", 0, int'(in_ready));
        if (out_valid !== 1'b0) report_mismatch("out_valid", 0, int'(out_valid));
        if (busy !== 1'b0) report_mismatch("busy", 0, int'(busy));

        send_command(CMD_LOAD_TW);
        send_stream(RING_SIZE / 2, pw);  // only w^0 .. w^7 go in

        for (int t = 0; t < NUM_RANDOM + NUM_STALLED; t++) begin
            for (int j = 0; j < RING_SIZE; j++) begin
                vec[j] = coef_t'(rand_below(MODULUS));
            end
            compute_expected();
            load_and_run(t >= NUM_RANDOM);
        end

        // impulse at 0 transforms to all ones
        for (int j = 0; j < RING_SIZE; j++) begin
            vec[j]  = (j == 0) ? coef_t'(1) : coef_t'(0);
            expv[j] = coef_t'(1);
        end
        load_and_run(1'b0);

        // impulse at 1 transforms to w^k
        for (int j = 0; j < RING_SIZE; j++) begin
            vec[j]  = (j == 1) ? coef_t'(1) : coef_t'(0);
            expv[j] = pw[j];
        end
        load_and_run(1'b0);

        $display("errors: %0d value, %0d timeout", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/tb_clock.sv
`default_nettype none

module tb_clock (
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam time HALF_PERIOD = 2ns;  // 4 ns period

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // reset held over the first two rising edges
    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire
